// File: src.f
+incdir+include
src/ScalerPkg.sv
src/RowMapper.sv
src/LineCache.sv
src/BlendPipeline.sv
src/VerticalStretch.sv
testbench/VerticalStretchTb.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log for a failure
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir

verilator --binary --timing --timescale 1ns/100ps -f src.f \
    --top-module VerticalStretchTb -o VerticalStretchSim > build.log 2>&1 \
    || { echo "Build failed, see build.log"; exit 1; }

./obj_dir/VerticalStretchSim > sim.log 2>&1

grep -q "Something failed" sim.log && { echo "Simulation failed, see sim.log"; exit 1; }
grep -q "Everything OK" sim.log || { echo "Simulation gave no result, see sim.log"; exit 1; }
echo "Simulation passed"

// File: include/StretchTbTasks.svh
`ifndef STRETCH_TB_TASKS_SVH
`define STRETCH_TB_TASKS_SVH

typedef logic [ScalerPkg::ROW_BITS-1:0] rowNumber;
typedef logic [ScalerPkg::SCALE_BITS-1:0] scaleFactor;

localparam int UNITY = 1 << ScalerPkg::SCALE_FRACTION_BITS;
// Source rows that the upstream model can deliver
localparam int SOURCE_ROWS = 128;

ScalerPkg::pixel565 sourceTable [SOURCE_ROWS][ScalerPkg::LINE_WIDTH];
int modelTag [2];
bit modelValid [2];
int modelOlder;
rowNumber expectedUpstream [$];
ScalerPkg::pixel565 expectedPixels [$];
int expectedPlace [$];
int sendQueue [$];
bit senderBusy;
bit pressureOn;

function automatic void fillSourceTable();
    for (int row = 0; row < SOURCE_ROWS; row++) begin
        for (int column = 0; column < ScalerPkg::LINE_WIDTH; column++) begin
            sourceTable[row][column] = 16'($urandom);
        end
    end
endfunction

function automatic void clearCacheModel();
    for (int slot = 0; slot < 2; slot++) begin
        modelTag[slot] = (1 << ScalerPkg::ROW_BITS) - 1;
        modelValid[slot] = 1'b0;
    end
    modelOlder = 0;
endfunction

function automatic void mapRow(input int outRow, input int factor,
                               output int upper, output int lower, output int fraction);
    int position;
    position = outRow * factor + factor / 2;
    // From 1.0 upward the sample point moves up by half a source row
    if (factor >= UNITY) begin
        position = position - UNITY / 2;
    end
    upper = position / UNITY;
    fraction = position % UNITY;
    lower = (fraction == 0) ? upper : upper + 1;
endfunction

function automatic ScalerPkg::pixel565 blendReference(input ScalerPkg::pixel565 upper,
                                                      input ScalerPkg::pixel565 lower,
                                                      input int fraction);
    int upperCoeff;
    int lowerCoeff;
    ScalerPkg::pixel565 blended;
    upperCoeff = (fraction == 0) ? UNITY : UNITY - 1 - fraction;
    lowerCoeff = fraction;
    blended.red = 5'((int'(upper.red) * upperCoeff + int'(lower.red) * lowerCoeff) / UNITY);
    blended.green = 6'((int'(upper.green) * upperCoeff
                        + int'(lower.green) * lowerCoeff) / UNITY);
    blended.blue = 5'((int'(upper.blue) * upperCoeff + int'(lower.blue) * lowerCoeff) / UNITY);
    return blended;
endfunction

function automatic bit holdsRow(input int row);
    return (modelTag[0] == row) || (modelTag[1] == row);
endfunction

function automatic int slotOf(input int row);
    return (modelTag[0] == row) ? 0 : 1;
endfunction

// Two-tag cache model, the older buffer is always the one that gets replaced
function automatic void predictFetches(input int upper, input int lower);
    int slot;
    while (!holdsRow(upper) || !holdsRow(lower)) begin
        modelTag[modelOlder] = (modelTag[1 - modelOlder] == upper) ? lower : upper;
        modelValid[modelOlder] = 1'b0;
        modelOlder = 1 - modelOlder;
    end
    slot = slotOf(upper);
    if (!modelValid[slot]) begin
        expectedUpstream.push_back(rowNumber'(upper));
        modelValid[slot] = 1'b1;
    end
    slot = slotOf(lower);
    if (!modelValid[slot]) begin
        expectedUpstream.push_back(rowNumber'(lower));
        modelValid[slot] = 1'b1;
    end
endfunction

task automatic comparePixel(input ScalerPkg::pixel565 actual,
                            input ScalerPkg::pixel565 expected, input string what);
    if (actual !== expected) begin
        $display("CHECK FAILED at %0t ns: %s pixel %h, expected %h",
                 $time, what, actual, expected);
        stopWithFailure();
    end
endtask

task automatic compareRow(input rowNumber actual, input rowNumber expected, input string what);
    if (actual !== expected) begin
        $display("CHECK FAILED at %0t ns: %s row %0d, expected %0d",
                 $time, what, actual, expected);
        stopWithFailure();
    end
endtask

// Upstream side answers each request with one row, leaving random gaps
initial begin : upstreamSender
    int row;
    upstreamPixelValid = 1'b0;
    upstreamPixel = '0;
    forever begin
        @(posedge scalerClock);
        if (sendQueue.size() != 0) begin
            row = sendQueue.pop_front();
            senderBusy = 1'b1;
            for (int column = 0; column < ScalerPkg::LINE_WIDTH; column++) begin
                upstreamPixelValid <= 1'b0;
                repeat ($urandom_range(2, 0)) @(posedge scalerClock);
                upstreamPixelValid <= 1'b1;
                upstreamPixel <= sourceTable[row][column];
                @(posedge scalerClock);
            end
            upstreamPixelValid <= 1'b0;
            senderBusy = 1'b0;
        end
    end
end

initial begin : requestMonitor
    forever begin
        @(posedge scalerClock);
        if (upstreamRowRequest) begin
            if (expectedUpstream.size() == 0) begin
                reportProblem("the DUT requested an upstream row the cache model did not expect");
            end else begin
                compareRow(upstreamRow, expectedUpstream.pop_front(), "upstream request");
                sendQueue.push_back(int'(upstreamRow));
            end
        end
    end
end

initial begin : pixelMonitor
    int place;
    forever begin
        @(posedge scalerClock);
        if (downstreamPixelValid && downstreamFull) begin
            reportProblem("a pixel came out while downstreamFull was high");
        end else if (downstreamPixelValid) begin
            if (expectedPixels.size() == 0) begin
                reportProblem("a pixel came out with no requested row outstanding");
            end else begin
                place = expectedPlace.pop_front();
                comparePixel(downstreamPixel, expectedPixels.pop_front(),
                             $sformatf("row %0d column %0d", place / ScalerPkg::LINE_WIDTH,
                                       place % ScalerPkg::LINE_WIDTH));
            end
        end
    end
end

task automatic waitNotBusy();
    int cycles;
    cycles = 0;
    @(posedge scalerClock);
    while (requestBusy) begin
        if (cycles > 20 * ScalerPkg::LINE_WIDTH) begin
            reportProblem("requestBusy stayed high and the next row could not be requested");
        end
        cycles++;
        @(posedge scalerClock);
    end
endtask

task automatic waitForDrain(input int rows);
    int cycles;
    cycles = 0;
    while (expectedPixels.size() != 0 || expectedUpstream.size() != 0
           || sendQueue.size() != 0 || senderBusy) begin
        if (cycles > 20 * ScalerPkg::LINE_WIDTH * rows) begin
            reportProblem("the requested rows did not all come out");
        end
        cycles++;
        @(posedge scalerClock);
    end
endtask

task automatic issueRow(input int outRow, input int upper, input int lower, input int fraction);
    if (lower >= SOURCE_ROWS) begin
        reportProblem("a test asked for a source row beyond the upstream table");
    end
    predictFetches(upper, lower);
    for (int column = 0; column < ScalerPkg::LINE_WIDTH; column++) begin
        expectedPixels.push_back(blendReference(sourceTable[upper][column],
                                                sourceTable[lower][column], fraction));
        expectedPlace.push_back(outRow * ScalerPkg::LINE_WIDTH + column);
    end
    waitNotBusy();
    downstreamRow <= rowNumber'(outRow);
    downstreamRowRequest <= 1'b1;
    @(posedge scalerClock);
    downstreamRowRequest <= 1'b0;
endtask

task automatic checkResetState();
    repeat (10) begin
        @(posedge scalerClock);
        if (requestBusy || upstreamRowRequest || downstreamPixelValid) begin
            reportProblem("an output went high after reset before any row was requested");
        end
    end
endtask

// At 1.0 every output row is its own source row
task automatic runIdentityTest();
    vShrinkFactor <= scaleFactor'(UNITY);
    for (int row = 0; row < IDENTITY_ROWS; row++) begin
        issueRow(row, row, row, 0);
    end
    waitForDrain(IDENTITY_ROWS);
endtask

task automatic runScaledRows(input int factor, input int firstRow, input int rows);
    int upper;
    int lower;
    int fraction;
    vShrinkFactor <= scaleFactor'(factor);
    for (int row = firstRow; row < firstRow + rows; row++) begin
        mapRow(row, factor, upper, lower, fraction);
        issueRow(row, upper, lower, fraction);
    end
    waitForDrain(rows);
endtask

task automatic runBlendTests();
    int factor;
    runScaledRows(32, 0, BLEND_ROWS);
    runScaledRows(48, 0, BLEND_ROWS);
    runScaledRows(80, 0, BLEND_ROWS);
    for (int pass = 0; pass < RANDOM_FACTORS; pass++) begin
        factor = $urandom_range(127, 1);
        runScaledRows(factor, 0, RANDOM_ROWS);
    end
endtask

// Long runs of neighbouring rows, where most source rows are already cached
task automatic runCacheReuseTest();
    runScaledRows(40, 10, STRETCH_RUN);
    runScaledRows(100, 20, SHRINK_RUN);
endtask

task automatic runBackPressureTest();
    pressureOn = 1'b1;
    runScaledRows(80, 4, PRESSURE_ROWS);
    pressureOn = 1'b0;
endtask

`endif

// File: testbench/VerticalStretchTb.sv
module VerticalStretchTb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLOCK_PERIOD = 10;
    localparam int RESET_CYCLES = 5;
    localparam int SEED = 56542;

    localparam int IDENTITY_ROWS = 8;
    localparam int BLEND_ROWS = 8;
    localparam int RANDOM_FACTORS = 4;
    localparam int RANDOM_ROWS = 6;
    localparam int STRETCH_RUN = 12;
    localparam int SHRINK_RUN = 8;
    localparam int PRESSURE_ROWS = 8;
    localparam int TOTAL_ROWS = IDENTITY_ROWS + 3 * BLEND_ROWS + RANDOM_FACTORS * RANDOM_ROWS
                                + STRETCH_RUN + SHRINK_RUN + PRESSURE_ROWS;

    logic scalerClock;
    logic reset;
    logic [ScalerPkg::SCALE_BITS-1:0] vShrinkFactor;
    logic downstreamRowRequest;
    logic [ScalerPkg::ROW_BITS-1:0] downstreamRow;
    logic requestBusy;
    logic upstreamRowRequest;
    logic [ScalerPkg::ROW_BITS-1:0] upstreamRow;
    logic upstreamPixelValid;
    ScalerPkg::pixel565 upstreamPixel;
    logic downstreamPixelValid;
    ScalerPkg::pixel565 downstreamPixel;
    logic downstreamFull;

    task automatic stopWithFailure();
        $display("Something failed");
        $fatal(1, "Stopping at the first error");
    endtask

    task automatic reportProblem(input string text);
        $display("ERROR at %0t ns: %s", $time, text);
        stopWithFailure();
    endtask

    `include "StretchTbTasks.svh"

    initial begin
        scalerClock = 1'b0;
        forever #(CLOCK_PERIOD / 2) scalerClock = ~scalerClock;
    end

    VerticalStretch dut0 (
        .scalerClock(scalerClock),
        .reset(reset),
        .vShrinkFactor(vShrinkFactor),
        .downstreamRowRequest(downstreamRowRequest),
        .downstreamRow(downstreamRow),
        .requestBusy(requestBusy),
        .upstreamRowRequest(upstreamRowRequest),
        .upstreamRow(upstreamRow),
        .upstreamPixelValid(upstreamPixelValid),
        .upstreamPixel(upstreamPixel),
        .downstreamPixelValid(downstreamPixelValid),
        .downstreamPixel(downstreamPixel),
        .downstreamFull(downstreamFull)
    );

    // Downstream level goes high at random only during the back-pressure test
    initial begin : pressureDriver
        downstreamFull = 1'b0;
        forever begin
            @(posedge scalerClock);
            downstreamFull <= pressureOn && ($urandom_range(1, 0) == 1);
        end
    end

    initial begin : watchdog
        #(20 * ScalerPkg::LINE_WIDTH * TOTAL_ROWS * CLOCK_PERIOD);
        reportProblem("timeout, the tests did not finish in the allowed time");
    end

    initial begin : testSequence
        void'($urandom(SEED));
        reset = 1'b1;
        vShrinkFactor = scaleFactor'(UNITY);
        downstreamRowRequest = 1'b0;
        downstreamRow = '0;
        fillSourceTable();
        clearCacheModel();
        repeat (RESET_CYCLES) @(posedge scalerClock);
        reset <= 1'b0;

        checkResetState();
        runIdentityTest();
        runBlendTests();
        runCacheReuseTest();
        runBackPressureTest();

        $display("Everything OK");
        $finish;
    end

endmodule

// File: src/VerticalStretch.sv
module VerticalStretch (
    input logic scalerClock,
    input logic reset,
    input logic [ScalerPkg::SCALE_BITS-1:0] vShrinkFactor,
    input logic downstreamRowRequest,
    input logic [ScalerPkg::ROW_BITS-1:0] downstreamRow,
    output logic requestBusy,
    output logic upstreamRowRequest,
    output logic [ScalerPkg::ROW_BITS-1:0] upstreamRow,
    input logic upstreamPixelValid,
    input ScalerPkg::pixel565 upstreamPixel,
    output logic downstreamPixelValid,
    output ScalerPkg::pixel565 downstreamPixel,
    input logic downstreamFull
);

    logic fillStart;
    logic fillSlot;
    logic fillDone;
    logic blendIdle;
    logic jobFree;
    logic jobValid;
    ScalerPkg::blendJob job;
    logic [ScalerPkg::LINE_WIDTH_BITS-1:0] readColumn;
    logic upperSlot;
    logic lowerSlot;
    ScalerPkg::columnPair columns;

    // Maps output rows onto source rows and manages the two line buffers
    RowMapper mapper (
        .scalerClock(scalerClock),
        .reset(reset),
        .vShrinkFactor(vShrinkFactor),
        .downstreamRowRequest(downstreamRowRequest),
        .downstreamRow(downstreamRow),
        .requestBusy(requestBusy),
        .upstreamRowRequest(upstreamRowRequest),
        .upstreamRow(upstreamRow),
        .fillStart(fillStart),
        .fillSlot(fillSlot),
        .fillDone(fillDone),
        .blendIdle(blendIdle),
        .jobFree(jobFree),
        .jobValid(jobValid),
        .job(job)
    );

    LineCache cache (
        .scalerClock(scalerClock),
        .reset(reset),
        .fillStart(fillStart),
        .fillSlot(fillSlot),
        .fillDone(fillDone),
        .upstreamPixelValid(upstreamPixelValid),
        .upstreamPixel(upstreamPixel),
        .readColumn(readColumn),
        .upperSlot(upperSlot),
        .lowerSlot(lowerSlot),
        .columns(columns)
    );

    BlendPipeline blender (
        .scalerClock(scalerClock),
        .reset(reset),
        .jobValid(jobValid),
        .job(job),
        .jobFree(jobFree),
        .blendIdle(blendIdle),
        .readColumn(readColumn),
        .upperSlot(upperSlot),
        .lowerSlot(lowerSlot),
        .columns(columns),
        .downstreamFull(downstreamFull),
        .downstreamPixelValid(downstreamPixelValid),
        .downstreamPixel(downstreamPixel)
    );

endmodule

// File: src/BlendPipeline.sv
module BlendPipeline (
    input logic scalerClock,
    input logic reset,
    input logic jobValid,
    input ScalerPkg::blendJob job,
    output logic jobFree,
    output logic blendIdle,
    output logic [ScalerPkg::LINE_WIDTH_BITS-1:0] readColumn,
    output logic upperSlot,
    output logic lowerSlot,
    input ScalerPkg::columnPair columns,
    input logic downstreamFull,
    output logic downstreamPixelValid,
    output ScalerPkg::pixel565 downstreamPixel
);

    typedef struct packed {
        logic [ScalerPkg::COLOR_WEIGHT_BITS-1:0] red;
        logic [ScalerPkg::COLOR_WEIGHT_BITS-1:0] green;
        logic [ScalerPkg::COLOR_WEIGHT_BITS-1:0] blue;
    } colorWeights;

    logic currentValid;
    logic heldValid;
    ScalerPkg::blendJob currentJob;
    ScalerPkg::blendJob heldJob;
    logic [ScalerPkg::LINE_WIDTH_BITS-1:0] columnCount;
    logic issue;
    logic lastIssue;
    logic promote;

    // Stage registers, named after the work done on their contents
    logic readValid;
    logic [ScalerPkg::LINE_WIDTH_BITS-1:0] issuedColumn;
    ScalerPkg::blendJob issuedJob;
    logic selectValid;
    ScalerPkg::columnPair selectPair;
    logic [ScalerPkg::SCALE_BITS-1:0] upperCoeff;
    logic [ScalerPkg::SCALE_BITS-1:0] lowerCoeff;
    logic [ScalerPkg::SCALE_BITS-1:0] upperCoeffNext;
    logic [ScalerPkg::SCALE_BITS-1:0] lowerCoeffNext;
    logic weightValid;
    colorWeights upperWeights;
    colorWeights lowerWeights;
    logic sumValid;

    function automatic colorWeights weighPixel(input ScalerPkg::pixel565 pixel,
                                               input logic [ScalerPkg::SCALE_BITS-1:0] coeff);
        colorWeights weights;
        logic [ScalerPkg::COLOR_WEIGHT_BITS-1:0] coeffWide;
        coeffWide = {{(ScalerPkg::COLOR_WEIGHT_BITS - ScalerPkg::SCALE_BITS){1'b0}}, coeff};
        weights.red = {{(ScalerPkg::COLOR_WEIGHT_BITS - ScalerPkg::RED_BITS){1'b0}},
                       pixel.red} * coeffWide;
        weights.green = {{(ScalerPkg::COLOR_WEIGHT_BITS - ScalerPkg::GREEN_BITS){1'b0}},
                         pixel.green} * coeffWide;
        weights.blue = {{(ScalerPkg::COLOR_WEIGHT_BITS - ScalerPkg::BLUE_BITS){1'b0}},
                        pixel.blue} * coeffWide;
        return weights;
    endfunction

    // Coefficients never sum past 1.0, so each total fits its weight width
    function automatic ScalerPkg::pixel565 blendPixel(input colorWeights upper,
                                                      input colorWeights lower);
        colorWeights total;
        ScalerPkg::pixel565 pixel;
        total.red = upper.red + lower.red;
        total.green = upper.green + lower.green;
        total.blue = upper.blue + lower.blue;
        pixel.red = total.red[ScalerPkg::SCALE_FRACTION_BITS +: ScalerPkg::RED_BITS];
        pixel.green = total.green[ScalerPkg::SCALE_FRACTION_BITS +: ScalerPkg::GREEN_BITS];
        pixel.blue = total.blue[ScalerPkg::SCALE_FRACTION_BITS +: ScalerPkg::BLUE_BITS];
        return pixel;
    endfunction

    assign issue = currentValid && !downstreamFull;
    assign lastIssue = issue && (columnCount == '1);
    assign promote = heldValid && (!currentValid || lastIssue);
    assign jobFree = !heldValid;
    assign blendIdle = !currentValid && !heldValid && !readValid;

    // While stalled the cache keeps re-reading the column already in flight
    assign readColumn = downstreamFull ? issuedColumn : columnCount;
    assign upperSlot = downstreamFull ? issuedJob.upperSlot : currentJob.upperSlot;
    assign lowerSlot = downstreamFull ? issuedJob.lowerSlot : currentJob.lowerSlot;

    assign downstreamPixelValid = sumValid && !downstreamFull;

    always_comb begin
        if (issuedJob.fraction == '0) begin
            upperCoeffNext = ScalerPkg::BLEND_UNITY;
            lowerCoeffNext = '0;
        end else begin
            upperCoeffNext = {1'b0, ~issuedJob.fraction};
            lowerCoeffNext = {1'b0, issuedJob.fraction};
        end
    end

    always_ff @(posedge scalerClock or posedge reset) begin
        if (reset) begin
            currentValid <= 1'b0;
            heldValid <= 1'b0;
            columnCount <= '0;
            readValid <= 1'b0;
            selectValid <= 1'b0;
            weightValid <= 1'b0;
            sumValid <= 1'b0;
        end else begin
            // The count wraps back to zero on the last column of every row
            if (issue) begin
                columnCount <= columnCount + {{(ScalerPkg::LINE_WIDTH_BITS-1){1'b0}}, 1'b1};
            end
            if (promote) begin
                currentValid <= 1'b1;
                heldValid <= 1'b0;
            end else if (lastIssue) begin
                currentValid <= 1'b0;
            end
            if (jobValid) begin
                heldValid <= 1'b1;
            end
            if (!downstreamFull) begin
                readValid <= issue;
                selectValid <= readValid;
                weightValid <= selectValid;
                sumValid <= weightValid;
            end
        end
    end

    always_ff @(posedge scalerClock) begin
        if (jobValid) begin
            heldJob <= job;
        end
        if (promote) begin
            currentJob <= heldJob;
        end
        if (!downstreamFull) begin
            if (issue) begin
                issuedColumn <= columnCount;
                issuedJob <= currentJob;
            end
            if (readValid) begin
                selectPair <= columns;
                upperCoeff <= upperCoeffNext;
                lowerCoeff <= lowerCoeffNext;
            end
            if (selectValid) begin
                upperWeights <= weighPixel(selectPair.upperPixel, upperCoeff);
                lowerWeights <= weighPixel(selectPair.lowerPixel, lowerCoeff);
            end
            if (weightValid) begin
                downstreamPixel <= blendPixel(upperWeights, lowerWeights);
            end
        end
    end

endmodule

// File: src/LineCache.sv
module LineCache (
    input logic scalerClock,
    input logic reset,
    input logic fillStart,
    input logic fillSlot,
    output logic fillDone,
    input logic upstreamPixelValid,
    input ScalerPkg::pixel565 upstreamPixel,
    input logic [ScalerPkg::LINE_WIDTH_BITS-1:0] readColumn,
    input logic upperSlot,
    input logic lowerSlot,
    output ScalerPkg::columnPair columns
);

    // Two line buffers, indexed by slot and column
    ScalerPkg::pixel565 lineRam [2][ScalerPkg::LINE_WIDTH];

    logic activeSlot;
    logic [ScalerPkg::LINE_WIDTH_BITS-1:0] fillColumn;

    ScalerPkg::pixel565 slotData [2];
    logic upperSelect;
    logic lowerSelect;

    always_ff @(posedge scalerClock or posedge reset) begin
        if (reset) begin
            activeSlot <= 1'b0;
            fillColumn <= '0;
            fillDone <= 1'b0;
        end else begin
            // The counter wraps to zero after the last column of a row
            fillDone <= upstreamPixelValid && (fillColumn == '1);
            if (fillStart) begin
                activeSlot <= fillSlot;
                fillColumn <= '0;
            end else if (upstreamPixelValid) begin
                fillColumn <= fillColumn + {{(ScalerPkg::LINE_WIDTH_BITS-1){1'b0}}, 1'b1};
            end
        end
    end

    always_ff @(posedge scalerClock) begin
        if (upstreamPixelValid) begin
            lineRam[activeSlot][fillColumn] <= upstreamPixel;
        end

        // Both buffers are read every cycle, the slot selects pick the order afterwards
        for (int slot = 0; slot < 2; slot++) begin
            slotData[slot] <= lineRam[slot][readColumn];
        end
        upperSelect <= upperSlot;
        lowerSelect <= lowerSlot;
    end

    always_comb begin
        columns.upperPixel = slotData[upperSelect];
        columns.lowerPixel = slotData[lowerSelect];
    end

endmodule

// File: src/RowMapper.sv
module RowMapper (
    input logic scalerClock,
    input logic reset,
    input logic [ScalerPkg::SCALE_BITS-1:0] vShrinkFactor,
    input logic downstreamRowRequest,
    input logic [ScalerPkg::ROW_BITS-1:0] downstreamRow,
    output logic requestBusy,
    output logic upstreamRowRequest,
    output logic [ScalerPkg::ROW_BITS-1:0] upstreamRow,
    output logic fillStart,
    output logic fillSlot,
    input logic fillDone,
    input logic blendIdle,
    input logic jobFree,
    output logic jobValid,
    output ScalerPkg::blendJob job
);

    typedef enum logic [1:0] {
        MAP_IDLE,
        MAP_CHECK,
        MAP_STORE,
        MAP_STALL
    } mapperState;

    mapperState state;
    logic [ScalerPkg::ROW_BITS-1:0] capturedRow;

    logic [ScalerPkg::ROW_COORD_BITS-1:0] rowExtended;
    logic [ScalerPkg::ROW_COORD_BITS-1:0] factorExtended;
    logic [ScalerPkg::ROW_COORD_BITS-1:0] halfFactor;
    logic [ScalerPkg::ROW_COORD_BITS-1:0] unityOffset;
    ScalerPkg::rowCoord coord;
    logic [ScalerPkg::ROW_BITS-1:0] upperRow;
    logic [ScalerPkg::ROW_BITS-1:0] lowerRow;

    // Buffer bookkeeping, one tag per line buffer
    logic [1:0][ScalerPkg::ROW_BITS-1:0] slotTag;
    logic [1:0] slotValid;
    logic [1:0] slotPending;
    logic slotOneOlder;

    logic upperSel;
    logic lowerSel;
    logic rowsTagged;
    logic rowsReady;
    logic upperNeedsFill;
    logic lowerNeedsFill;
    logic fillBusy;
    logic fillRequest;
    logic [ScalerPkg::ROW_BITS-1:0] fillRow;
    logic fillTarget;
    logic issueJob;
    logic [ScalerPkg::ROW_BITS-1:0] replaceTag;

    always_comb begin
        rowExtended = {{ScalerPkg::SCALE_FRACTION_BITS{1'b0}}, capturedRow};
        factorExtended = {{(ScalerPkg::ROW_COORD_BITS - ScalerPkg::SCALE_BITS){1'b0}},
                          vShrinkFactor};
        halfFactor = {{(ScalerPkg::ROW_COORD_BITS - ScalerPkg::SCALE_BITS + 1){1'b0}},
                      vShrinkFactor[ScalerPkg::SCALE_BITS-1:1]};
        // Factors of 1.0 and above sample half a source row earlier
        unityOffset = '0;
        if (vShrinkFactor[ScalerPkg::SCALE_BITS-1]) begin
            unityOffset[ScalerPkg::SCALE_FRACTION_BITS-1] = 1'b1;
        end
        coord = rowExtended * factorExtended + halfFactor - unityOffset;

        upperRow = coord.whole;
        if (coord.fraction == '0) begin
            lowerRow = coord.whole;
        end else begin
            lowerRow = coord.whole + {{(ScalerPkg::ROW_BITS-1){1'b0}}, 1'b1};
        end

        // Slot 0 wins when it matches, otherwise slot 1 is the only candidate
        upperSel = (slotTag[0] != upperRow);
        lowerSel = (slotTag[0] != lowerRow);
        rowsTagged = (slotTag[upperSel] == upperRow) && (slotTag[lowerSel] == lowerRow);
        rowsReady = rowsTagged && slotValid[upperSel] && slotValid[lowerSel];

        upperNeedsFill = rowsTagged && !slotValid[upperSel] && !slotPending[upperSel];
        lowerNeedsFill = rowsTagged && !slotValid[lowerSel] && !slotPending[lowerSel];
        fillBusy = |slotPending;

        // LineCache follows one fill at a time, so requests are serialized
        fillRequest = (state == MAP_STORE) && !fillBusy && (upperNeedsFill || lowerNeedsFill);
        fillRow = upperNeedsFill ? upperRow : lowerRow;
        fillTarget = upperNeedsFill ? upperSel : lowerSel;

        issueJob = ((state == MAP_CHECK) || (state == MAP_STORE)) && rowsReady && jobFree;

        // Keep the row that is still useful in the other slot
        replaceTag = (slotTag[!slotOneOlder] == upperRow) ? lowerRow : upperRow;
    end

    always_ff @(posedge scalerClock or posedge reset) begin
        if (reset) begin
            state <= MAP_IDLE;
            requestBusy <= 1'b0;
            upstreamRowRequest <= 1'b0;
            fillStart <= 1'b0;
            jobValid <= 1'b0;
            slotTag <= '1;
            slotValid <= '0;
            slotPending <= '0;
            slotOneOlder <= 1'b0;
        end else begin
            upstreamRowRequest <= 1'b0;
            fillStart <= 1'b0;
            jobValid <= 1'b0;

            if (fillDone) begin
                slotValid <= slotValid | slotPending;
                slotPending <= '0;
            end

            if (fillRequest) begin
                upstreamRowRequest <= 1'b1;
                fillStart <= 1'b1;
                slotPending[fillTarget] <= 1'b1;
            end

            if (issueJob) begin
                jobValid <= 1'b1;
                requestBusy <= 1'b0;
            end

            case (state)
                MAP_IDLE: begin
                    if (downstreamRowRequest) begin
                        requestBusy <= 1'b1;
                        state <= MAP_CHECK;
                    end
                end
                MAP_CHECK: begin
                    if (!rowsTagged) begin
                        state <= MAP_STALL;
                    end else if (issueJob) begin
                        state <= MAP_IDLE;
                    end else begin
                        state <= MAP_STORE;
                    end
                end
                MAP_STORE: begin
                    if (issueJob) begin
                        state <= MAP_IDLE;
                    end
                end
                MAP_STALL: begin
                    // Retagging is safe only once nothing reads or fills a buffer
                    if (blendIdle && !fillBusy) begin
                        slotTag[slotOneOlder] <= replaceTag;
                        slotValid[slotOneOlder] <= 1'b0;
                        slotOneOlder <= !slotOneOlder;
                        state <= MAP_CHECK;
                    end
                end
                default: begin
                    state <= MAP_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge scalerClock) begin
        if (state == MAP_IDLE && downstreamRowRequest) begin
            capturedRow <= downstreamRow;
        end
        if (fillRequest) begin
            upstreamRow <= fillRow;
            fillSlot <= fillTarget;
        end
        if (issueJob) begin
            job.upperSlot <= upperSel;
            job.lowerSlot <= lowerSel;
            job.fraction <= coord.fraction;
        end
    end

endmodule

// File: src/ScalerPkg.sv
package ScalerPkg;

    // The shrink factor is a fixed-point value where BLEND_UNITY means 1.0
    localparam int SCALE_FRACTION_BITS = 6;
    localparam int SCALE_BITS = SCALE_FRACTION_BITS + 1;

    localparam int ROW_BITS = 11;
    localparam int ROW_COORD_BITS = ROW_BITS + SCALE_FRACTION_BITS;

    localparam int LINE_WIDTH_BITS = 6;
    localparam int LINE_WIDTH = 1 << LINE_WIDTH_BITS;

    // RGB 5-6-5 component widths
    localparam int RED_BITS = 5;
    localparam int GREEN_BITS = 6;
    localparam int BLUE_BITS = 5;
    localparam int COLOR_COMPONENT_BITS_MAX = 6;
    localparam int COLOR_WEIGHT_BITS = COLOR_COMPONENT_BITS_MAX + SCALE_FRACTION_BITS;

    localparam logic [SCALE_BITS-1:0] BLEND_UNITY = 1 << SCALE_FRACTION_BITS;

    typedef struct packed {
        logic [RED_BITS-1:0] red;
        logic [GREEN_BITS-1:0] green;
        logic [BLUE_BITS-1:0] blue;
    } pixel565;

    // Upstream coordinate of an output row, whole row plus blend fraction
    typedef struct packed {
        logic [ROW_BITS-1:0] whole;
        logic [SCALE_FRACTION_BITS-1:0] fraction;
    } rowCoord;

    // One output row to blend, naming the buffer slots that hold its source rows
    typedef struct packed {
        logic upperSlot;
        logic lowerSlot;
        logic [SCALE_FRACTION_BITS-1:0] fraction;
    } blendJob;

    typedef struct packed {
        pixel565 upperPixel;
        pixel565 lowerPixel;
    } columnPair;

endpackage
